// ==== logic/rvIsaPkg.sv ====
package rvIsaPkg;

	localparam logic [6:0] opLoad   = 7'b0000011;
	localparam logic [6:0] opStore  = 7'b0100011;
	localparam logic [6:0] opBranch = 7'b1100011;
	localparam logic [6:0] opJal    = 7'b1101111;
	localparam logic [6:0] opJalr   = 7'b1100111;
	localparam logic [6:0] opOpImm  = 7'b0010011;
	localparam logic [6:0] opOp     = 7'b0110011;
	localparam logic [6:0] opLui    = 7'b0110111;
	localparam logic [6:0] opAuipc  = 7'b0010111;

	// arithmetic first, then the six branch compares
	typedef enum logic [3:0] {
		aluAdd, aluSub, aluSll, aluSlt, aluSltu, aluXor, aluSrl, aluSra,
		aluOr, aluAnd, aluEq, aluNe, aluLt, aluGe, aluLtu, aluGeu
	} aluOpT;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} rTypeT;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} iTypeT;

	typedef struct packed {
		logic [6:0] immHi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] immLo;
		logic [6:0] opcode;
	} sTypeT;

	typedef struct packed {
		logic       imm12;
		logic [5:0] imm10to5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm4to1;
		logic       imm11;
		logic [6:0] opcode;
	} bTypeT;

	typedef struct packed {
		logic [19:0] imm;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} uTypeT;

	typedef struct packed {
		logic       imm20;
		logic [9:0] imm10to1;
		logic       imm11;
		logic [7:0] imm19to12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} jTypeT;

	// one fetched word, six ways to read it
	typedef union packed {
		rTypeT rType;
		iTypeT iType;
		sTypeT sType;
		bTypeT bType;
		uTypeT uType;
		jTypeT jType;
	} instrWordT;

endpackage

// ==== logic/rvMemPkg.sv ====
package rvMemPkg;

	// same encoding as funct3 of loads and stores
	typedef enum logic [2:0] {
		memByte  = 3'b000,
		memHalf  = 3'b001,
		memWord  = 3'b010,
		memByteU = 3'b100,
		memHalfU = 3'b101
	} memWidthT;

	// lane patterns before shifting to the byte offset
	localparam logic [3:0] beByte = 4'b0001;
	localparam logic [3:0] beHalf = 4'b0011;
	localparam logic [3:0] beWord = 4'b1111;

	localparam logic [31:0] haltInstrFirst  = 32'h00c00093; // addi x1, x0, 12
	localparam logic [31:0] haltInstrSecond = 32'h00008067; // jalr x0, 0(x1)

endpackage

// ==== logic/fetchUnit.sv ====
`timescale 1ns/1ns

module fetchUnit #(
	parameter int memAddrWidth = 12
) (
	input  logic                    CLK,
	input  logic                    RSTn,
	input  logic [31:0]             iMemDi,
	input  logic [31:0]             imm,
	input  logic [31:0]             aluResult,
	input  logic                    cmpTrue,
	input  logic                    isBranch,
	input  logic                    isJal,
	input  logic                    isJalr,
	output logic [31:0]             pc,
	output logic [31:0]             pcPlus4,
	output logic [memAddrWidth-1:0] iMemAddr,
	output logic                    iMemCsn,
	output logic                    halt,
	output logic [31:0]             numInst
);

	logic [31:0] nextPc;
	logic [31:0] pcPlusImm;
	logic        lastWasFirst; // previous retired word opened the halt pair
	logic        halted;

	assign pcPlus4   = pc + 32'd4;
	assign pcPlusImm = pc + imm;
	assign iMemAddr  = pc[memAddrWidth-1:0]; // byte address
	assign iMemCsn   = RSTn;
	assign halt      = halted | (lastWasFirst & (iMemDi == rvMemPkg::haltInstrSecond));

	always_comb begin
		if (isJalr)
			nextPc = {aluResult[31:1], 1'b0}; // rs1 + imm with bit 0 dropped
		else if (isJal || (isBranch && cmpTrue))
			nextPc = pcPlusImm;
		else
			nextPc = pcPlus4;
	end

	always_ff @(posedge CLK) begin
		if (RSTn) begin
			pc           <= '0;
			numInst      <= '0;
			lastWasFirst <= 1'b0;
			halted       <= 1'b0;
		end else begin
			halted <= halt; // sticky once seen
			if (!halt) begin
				pc           <= nextPc;
				numInst      <= numInst + 32'd1;
				lastWasFirst <= (iMemDi == rvMemPkg::haltInstrFirst);
			end
		end
	end

	pcAligned: assert property (@(posedge CLK) disable iff (RSTn) pc[1:0] == 2'b00)
		else $error("pc lost word alignment: %h", pc);

endmodule

// ==== logic/instrDecoder.sv ====
`timescale 1ns/1ns

module instrDecoder (
	input  logic [31:0]        instr,
	input  logic               RSTn,
	output logic [4:0]         rfRa1,
	output logic [4:0]         rfRa2,
	output logic [4:0]         rfWa1,
	output logic [31:0]        imm,
	output rvIsaPkg::aluOpT    aluOp,
	output logic               useImm,
	output logic               zeroSrc1,
	output logic               isLoad,
	output logic               isStore,
	output logic               isBranch,
	output logic               isJal,
	output logic               isJalr,
	output logic               isAuipc,
	output rvMemPkg::memWidthT memWidth,
	output logic               rfWe
);

	rvIsaPkg::instrWordT iw;
	logic [31:0] immI;
	logic [31:0] immS;
	logic [31:0] immB;
	logic [31:0] immU;
	logic [31:0] immJ;
	logic        writesRd;

	// funct3 plus the funct7 bit 5 modifier
	function automatic rvIsaPkg::aluOpT arithOp(input logic [2:0] f3, input logic alt);
		rvIsaPkg::aluOpT op;
		case (f3)
			3'b000:  op = alt ? rvIsaPkg::aluSub : rvIsaPkg::aluAdd;
			3'b001:  op = rvIsaPkg::aluSll;
			3'b010:  op = rvIsaPkg::aluSlt;
			3'b011:  op = rvIsaPkg::aluSltu;
			3'b100:  op = rvIsaPkg::aluXor;
			3'b101:  op = alt ? rvIsaPkg::aluSra : rvIsaPkg::aluSrl;
			3'b110:  op = rvIsaPkg::aluOr;
			default: op = rvIsaPkg::aluAnd;
		endcase
		return op;
	endfunction

	assign iw    = instr;
	assign rfRa1 = iw.rType.rs1;
	assign rfRa2 = iw.rType.rs2;
	assign rfWa1 = iw.rType.rd;

	assign immI = {{20{iw.iType.imm[11]}}, iw.iType.imm};
	assign immS = {{20{iw.sType.immHi[6]}}, iw.sType.immHi, iw.sType.immLo};
	assign immB = {{19{iw.bType.imm12}}, iw.bType.imm12, iw.bType.imm11,
		iw.bType.imm10to5, iw.bType.imm4to1, 1'b0};
	assign immU = {iw.uType.imm, 12'h000};
	assign immJ = {{11{iw.jType.imm20}}, iw.jType.imm20, iw.jType.imm19to12,
		iw.jType.imm11, iw.jType.imm10to1, 1'b0};

	assign memWidth = rvMemPkg::memWidthT'(iw.iType.funct3);
	assign rfWe     = writesRd & ~RSTn;

	always_comb begin
		imm      = '0;
		aluOp    = rvIsaPkg::aluAdd;
		useImm   = 1'b0;
		zeroSrc1 = 1'b0;
		isLoad   = 1'b0;
		isStore  = 1'b0;
		isBranch = 1'b0;
		isJal    = 1'b0;
		isJalr   = 1'b0;
		isAuipc  = 1'b0;
		writesRd = 1'b0;
		case (iw.rType.opcode)
			rvIsaPkg::opLoad: begin
				imm      = immI;
				useImm   = 1'b1;
				isLoad   = 1'b1;
				writesRd = 1'b1;
			end
			rvIsaPkg::opStore: begin
				imm     = immS;
				useImm  = 1'b1;
				isStore = 1'b1;
			end
			rvIsaPkg::opBranch: begin
				imm      = immB;
				isBranch = 1'b1;
				case (iw.bType.funct3)
					3'b000:  aluOp = rvIsaPkg::aluEq;
					3'b001:  aluOp = rvIsaPkg::aluNe;
					3'b100:  aluOp = rvIsaPkg::aluLt;
					3'b101:  aluOp = rvIsaPkg::aluGe;
					3'b110:  aluOp = rvIsaPkg::aluLtu;
					default: aluOp = rvIsaPkg::aluGeu;
				endcase
			end
			rvIsaPkg::opJal: begin
				imm      = immJ;
				isJal    = 1'b1;
				writesRd = 1'b1;
			end
			rvIsaPkg::opJalr: begin
				imm      = immI;
				useImm   = 1'b1;
				isJalr   = 1'b1;
				writesRd = 1'b1;
			end
			rvIsaPkg::opOpImm: begin
				imm      = immI;
				useImm   = 1'b1;
				writesRd = 1'b1;
				// bit 30 only picks srai since there is no subi
				aluOp    = arithOp(iw.iType.funct3,
					(iw.iType.funct3 == 3'b101) & iw.rType.funct7[5]);
			end
			rvIsaPkg::opOp: begin
				writesRd = 1'b1;
				aluOp    = arithOp(iw.rType.funct3, iw.rType.funct7[5]);
			end
			rvIsaPkg::opLui: begin
				imm      = immU;
				useImm   = 1'b1;
				zeroSrc1 = 1'b1; // 0 + imm
				writesRd = 1'b1;
			end
			rvIsaPkg::opAuipc: begin
				imm      = immU;
				useImm   = 1'b1;
				isAuipc  = 1'b1;
				writesRd = 1'b1;
			end
			default: ;
		endcase
	end

	// loads know five width codes, stores only three
	always_comb
		widthDefined: assert final (RSTn || !(isLoad || isStore) ||
			(iw.iType.funct3 != 3'b011 && !(isStore && iw.iType.funct3[2]) &&
			iw.iType.funct3[2:1] != 2'b11))
			else $error("undefined load or store width %b", iw.iType.funct3);

endmodule

// ==== logic/aluUnit.sv ====
`timescale 1ns/1ns

module aluUnit (
	input  logic [31:0]     rfRd1,
	input  logic [31:0]     rfRd2,
	input  logic [31:0]     imm,
	input  logic            useImm,
	input  logic            zeroSrc1,
	input  rvIsaPkg::aluOpT aluOp,
	output logic [31:0]     aluResult,
	output logic            cmpTrue
);

	logic [31:0] srcA;
	logic [31:0] srcB;
	logic [4:0]  shamt;

	assign srcA  = zeroSrc1 ? 32'h0 : rfRd1;
	assign srcB  = useImm ? imm : rfRd2;
	assign shamt = srcB[4:0];

	always_comb begin
		cmpTrue = 1'b0;
		case (aluOp)
			rvIsaPkg::aluEq:  cmpTrue = (srcA == srcB);
			rvIsaPkg::aluNe:  cmpTrue = (srcA != srcB);
			rvIsaPkg::aluLt:  cmpTrue = ($signed(srcA) < $signed(srcB));
			rvIsaPkg::aluGe:  cmpTrue = ($signed(srcA) >= $signed(srcB));
			rvIsaPkg::aluLtu: cmpTrue = (srcA < srcB);
			rvIsaPkg::aluGeu: cmpTrue = (srcA >= srcB);
			default: ;
		endcase
	end

	always_comb begin
		case (aluOp)
			rvIsaPkg::aluAdd:  aluResult = srcA + srcB;
			rvIsaPkg::aluSub:  aluResult = srcA - srcB;
			rvIsaPkg::aluSll:  aluResult = srcA << shamt;
			rvIsaPkg::aluSlt:  aluResult = {31'b0, $signed(srcA) < $signed(srcB)};
			rvIsaPkg::aluSltu: aluResult = {31'b0, srcA < srcB};
			rvIsaPkg::aluXor:  aluResult = srcA ^ srcB;
			rvIsaPkg::aluSrl:  aluResult = srcA >> shamt;
			rvIsaPkg::aluSra:  aluResult = $unsigned($signed(srcA) >>> shamt);
			rvIsaPkg::aluOr:   aluResult = srcA | srcB;
			rvIsaPkg::aluAnd:  aluResult = srcA & srcB;
			default:           aluResult = {31'b0, cmpTrue}; // branch compares
		endcase
	end

endmodule

// ==== logic/memAccessUnit.sv ====
`timescale 1ns/1ns

module memAccessUnit #(
	parameter int memAddrWidth = 12
) (
	input  logic                    RSTn,
	input  logic [31:0]             aluResult,
	input  logic [31:0]             rfRd2,
	input  logic [31:0]             dMemDi,
	input  logic [31:0]             pc,
	input  logic [31:0]             pcPlus4,
	input  logic [31:0]             imm,
	input  logic                    isLoad,
	input  logic                    isStore,
	input  logic                    isJal,
	input  logic                    isJalr,
	input  logic                    isAuipc,
	input  logic                    isBranch,
	input  logic                    cmpTrue,
	input  rvMemPkg::memWidthT      memWidth,
	output logic [memAddrWidth-1:0] dMemAddr,
	output logic [31:0]             dMemDout,
	output logic [3:0]              dMemBe,
	output logic                    dMemWen,
	output logic                    dMemCsn,
	output logic [31:0]             rfWd,
	output logic [31:0]             outputPort
);

	logic [1:0]  byteOff;
	logic [3:0]  laneMask;
	logic [31:0] laneWord; // addressed lane moved down to bit 0
	logic [31:0] loadData;
	logic        halfAccess;
	logic        wordAccess;

	assign byteOff  = aluResult[1:0];
	assign dMemAddr = aluResult[memAddrWidth+1:2]; // word address
	assign dMemDout = rfRd2 << {byteOff, 3'b000};
	assign dMemBe   = (isLoad | isStore) ? laneMask : 4'b0000;
	assign dMemWen  = ~(isStore & ~RSTn); // active low
	assign dMemCsn  = RSTn;
	assign laneWord = dMemDi >> {byteOff, 3'b000};

	assign halfAccess = (memWidth == rvMemPkg::memHalf) || (memWidth == rvMemPkg::memHalfU);
	assign wordAccess = (memWidth == rvMemPkg::memWord);

	always_comb begin
		if (wordAccess)
			laneMask = rvMemPkg::beWord;
		else if (halfAccess)
			laneMask = rvMemPkg::beHalf << byteOff;
		else
			laneMask = rvMemPkg::beByte << byteOff;
	end

	always_comb begin
		case (memWidth)
			rvMemPkg::memByte:  loadData = {{24{laneWord[7]}}, laneWord[7:0]};
			rvMemPkg::memByteU: loadData = {24'h0, laneWord[7:0]};
			rvMemPkg::memHalf:  loadData = {{16{laneWord[15]}}, laneWord[15:0]};
			rvMemPkg::memHalfU: loadData = {16'h0, laneWord[15:0]};
			default:            loadData = dMemDi;
		endcase
	end

	always_comb begin
		if (isJal || isJalr)
			rfWd = pcPlus4; // link value
		else if (isAuipc)
			rfWd = pc + imm;
		else if (isLoad)
			rfWd = loadData;
		else
			rfWd = aluResult;
	end

	assign outputPort = isBranch ? {31'b0, cmpTrue} : rfWd;

	// effective address comes from the register file and decoder
	always_comb
		accessAligned: assert final (RSTn || !(isLoad || isStore) ||
			!((halfAccess && byteOff[0]) || (wordAccess && byteOff != 2'b00)))
			else $error("misaligned data access at %h", aluResult);

endmodule

// ==== logic/riscvCore.sv ====
`timescale 1ns/1ns

module riscvCore #(
	parameter int memAddrWidth = 12
) (
	input  logic                    CLK,
	input  logic                    RSTn,
	input  logic [31:0]             iMemDi,
	input  logic [31:0]             dMemDi,
	input  logic [31:0]             rfRd1,
	input  logic [31:0]             rfRd2,
	output logic                    iMemCsn,
	output logic [memAddrWidth-1:0] iMemAddr,
	output logic                    dMemCsn,
	output logic [31:0]             dMemDout,
	output logic [memAddrWidth-1:0] dMemAddr,
	output logic                    dMemWen,
	output logic [3:0]              dMemBe,
	output logic                    rfWe,
	output logic [4:0]              rfRa1,
	output logic [4:0]              rfRa2,
	output logic [4:0]              rfWa1,
	output logic [31:0]             rfWd,
	output logic                    halt,
	output logic [31:0]             numInst,
	output logic [31:0]             outputPort
);

	logic [31:0]        pc;
	logic [31:0]        pcPlus4;
	logic [31:0]        imm;
	logic [31:0]        aluResult;
	rvIsaPkg::aluOpT    aluOp;
	rvMemPkg::memWidthT memWidth;
	logic               useImm;
	logic               zeroSrc1;
	logic               isLoad;
	logic               isStore;
	logic               isBranch;
	logic               isJal;
	logic               isJalr;
	logic               isAuipc;
	logic               cmpTrue;

	fetchUnit #(.memAddrWidth(memAddrWidth)) fetch (
		.CLK(CLK), .RSTn(RSTn), .iMemDi(iMemDi), .imm(imm), .aluResult(aluResult),
		.cmpTrue(cmpTrue), .isBranch(isBranch), .isJal(isJal), .isJalr(isJalr),
		.pc(pc), .pcPlus4(pcPlus4), .iMemAddr(iMemAddr), .iMemCsn(iMemCsn),
		.halt(halt), .numInst(numInst)
	);

	instrDecoder decode (
		.instr(iMemDi), .RSTn(RSTn), .rfRa1(rfRa1), .rfRa2(rfRa2), .rfWa1(rfWa1),
		.imm(imm), .aluOp(aluOp), .useImm(useImm), .zeroSrc1(zeroSrc1),
		.isLoad(isLoad), .isStore(isStore), .isBranch(isBranch), .isJal(isJal),
		.isJalr(isJalr), .isAuipc(isAuipc), .memWidth(memWidth), .rfWe(rfWe)
	);

	aluUnit alu (
		.rfRd1(rfRd1), .rfRd2(rfRd2), .imm(imm), .useImm(useImm), .zeroSrc1(zeroSrc1),
		.aluOp(aluOp), .aluResult(aluResult), .cmpTrue(cmpTrue)
	);

	memAccessUnit #(.memAddrWidth(memAddrWidth)) memAccess (
		.RSTn(RSTn), .aluResult(aluResult), .rfRd2(rfRd2), .dMemDi(dMemDi),
		.pc(pc), .pcPlus4(pcPlus4), .imm(imm), .isLoad(isLoad), .isStore(isStore),
		.isJal(isJal), .isJalr(isJalr), .isAuipc(isAuipc), .isBranch(isBranch),
		.cmpTrue(cmpTrue), .memWidth(memWidth), .dMemAddr(dMemAddr),
		.dMemDout(dMemDout), .dMemBe(dMemBe), .dMemWen(dMemWen), .dMemCsn(dMemCsn),
		.rfWd(rfWd), .outputPort(outputPort)
	);

endmodule

// ==== tests/coreModels.sv ====
`timescale 1ns/1ns

// read-only program store, byte address in, word out
module instrMemModel #(
	parameter int memAddrWidth = 12
) (
	input  logic [memAddrWidth-1:0] addr,
	output logic [31:0]             data
);

	logic [31:0] words [0:(1<<(memAddrWidth-2))-1]; // loaded by the testbench

	assign data = words[addr[memAddrWidth-1:2]];

endmodule

module dataMemModel #(
	parameter int memAddrWidth = 12
) (
	input  logic                    CLK,
	input  logic                    csn,
	input  logic                    wen, // active low
	input  logic [3:0]              be,
	input  logic [memAddrWidth-1:0] addr, // word address
	input  logic [31:0]             din,
	output logic [31:0]             dout
);

	logic [31:0] words [0:(1<<memAddrWidth)-1];

	initial begin
		for (int i = 0; i < (1 << memAddrWidth); i++)
			words[i] = 32'h0;
	end

	assign dout = words[addr];

	always @(posedge CLK) begin
		if (!csn && !wen) begin
			for (int b = 0; b < 4; b++)
				if (be[b])
					words[addr][8*b +: 8] <= din[8*b +: 8];
		end
	end

endmodule

module regFileModel (
	input  logic        CLK,
	input  logic        we,
	input  logic [4:0]  ra1,
	input  logic [4:0]  ra2,
	input  logic [4:0]  wa,
	input  logic [31:0] wd,
	output logic [31:0] rd1,
	output logic [31:0] rd2
);

	logic [31:0] regs [0:31];

	initial begin
		for (int i = 0; i < 32; i++)
			regs[i] = 32'h0;
	end

	assign rd1 = (ra1 == 5'd0) ? 32'h0 : regs[ra1]; // x0 hardwired
	assign rd2 = (ra2 == 5'd0) ? 32'h0 : regs[ra2];

	always @(posedge CLK) begin
		if (we && wa != 5'd0)
			regs[wa] <= wd;
	end

endmodule

// ==== tests/coreTb.sv ====
`timescale 1ns/1ns

module coreTb;

	localparam int addrWidth = 12;
	localparam int clkPeriod = 20;
	localparam logic [31:0] fillerWord = 32'hfff00f93; // addi x31, x0, -1

	logic                 CLK;
	logic                 RSTn;
	logic [31:0]          iMemDi;
	logic [31:0]          dMemDi;
	logic [31:0]          rfRd1;
	logic [31:0]          rfRd2;
	logic                 iMemCsn;
	logic [addrWidth-1:0] iMemAddr;
	logic                 dMemCsn;
	logic [31:0]          dMemDout;
	logic [addrWidth-1:0] dMemAddr;
	logic                 dMemWen;
	logic [3:0]           dMemBe;
	logic                 rfWe;
	logic [4:0]           rfRa1;
	logic [4:0]           rfRa2;
	logic [4:0]           rfWa1;
	logic [31:0]          rfWd;
	logic                 halt;
	logic [31:0]          numInst;
	logic [31:0]          outputPort;

	logic [31:0] progWords[$];
	logic [31:0] progWant[$];
	bit          progLive[$]; // 0 marks a slot that a taken jump skips
	int          errors;
	int          checks;

	riscvCore #(.memAddrWidth(addrWidth)) UUT (
		.CLK(CLK), .RSTn(RSTn), .iMemDi(iMemDi), .dMemDi(dMemDi), .rfRd1(rfRd1),
		.rfRd2(rfRd2), .iMemCsn(iMemCsn), .iMemAddr(iMemAddr), .dMemCsn(dMemCsn),
		.dMemDout(dMemDout), .dMemAddr(dMemAddr), .dMemWen(dMemWen), .dMemBe(dMemBe),
		.rfWe(rfWe), .rfRa1(rfRa1), .rfRa2(rfRa2), .rfWa1(rfWa1), .rfWd(rfWd),
		.halt(halt), .numInst(numInst), .outputPort(outputPort)
	);

	instrMemModel #(.memAddrWidth(addrWidth)) imem (.addr(iMemAddr), .data(iMemDi));

	dataMemModel #(.memAddrWidth(addrWidth)) dmem (
		.CLK(CLK), .csn(dMemCsn), .wen(dMemWen), .be(dMemBe), .addr(dMemAddr),
		.din(dMemDout), .dout(dMemDi)
	);

	regFileModel rf (
		.CLK(CLK), .we(rfWe), .ra1(rfRa1), .ra2(rfRa2), .wa(rfWa1), .wd(rfWd),
		.rd1(rfRd1), .rd2(rfRd2)
	);

	always #(clkPeriod/2) CLK = ~CLK;

	task automatic addRow(input logic [31:0] word, input logic [31:0] want, input bit live);
		progWords.push_back(word);
		progWant.push_back(want);
		progLive.push_back(live);
	endtask

	task automatic checkValue(input string what, input logic [31:0] got,
		input logic [31:0] want);
		checks++;
		assert (got === want)
		else begin
			errors++;
			$display("Error at %0t ns: %s is %h, expected %h", $time, what, got, want);
		end
	endtask

	// row address is 4 * index, expected values worked out by hand
	task automatic buildProgram();
		addRow(32'h00500093, 32'h00000005, 1); // addi x1, x0, 5
		addRow(32'hffd00113, 32'hfffffffd, 1); // addi x2, x0, -3
		addRow(32'h002081b3, 32'h00000002, 1); // add x3, x1, x2
		addRow(32'h40208233, 32'h00000008, 1); // sub x4, x1, x2
		addRow(32'h00409293, 32'h00000050, 1); // slli x5, x1, 4
		addRow(32'h01c15313, 32'h0000000f, 1); // srli x6, x2, 28
		addRow(32'h40115393, 32'hfffffffe, 1); // srai x7, x2, 1
		addRow(32'h00109433, 32'h000000a0, 1); // sll x8, x1, x1
		addRow(32'h001124b3, 32'h00000001, 1); // slt x9, x2, x1
		addRow(32'h00113533, 32'h00000000, 1); // sltu x10, x2, x1
		addRow(32'h0ff0c593, 32'h000000fa, 1); // xori x11, x1, 0xff
		addRow(32'h0040e633, 32'h0000000d, 1); // or x12, x1, x4
		addRow(32'h005176b3, 32'h00000050, 1); // and x13, x2, x5
		addRow(32'h12345737, 32'h12345000, 1); // lui x14, 0x12345
		addRow(32'h00001797, 32'h00001038, 1); // auipc x15, 1 at 0x38
		addRow(32'h87654837, 32'h87654000, 1); // lui x16, 0x87654
		addRow(32'h32180813, 32'h87654321, 1); // addi x16, x16, 0x321
		addRow(32'h10000893, 32'h00000100, 1); // addi x17, x0, 0x100
		// stores report their effective address
		addRow(32'h0108a023, 32'h00000100, 1); // sw x16, 0(x17)
		addRow(32'h001880a3, 32'h00000101, 1); // sb x1, 1(x17)
		addRow(32'h00289123, 32'h00000102, 1); // sh x2, 2(x17) word now fffd0521
		addRow(32'h00188903, 32'h00000005, 1); // lb x18, 1(x17)
		addRow(32'h00388983, 32'hffffffff, 1); // lb x19, 3(x17)
		addRow(32'h0028ca03, 32'h000000fd, 1); // lbu x20, 2(x17)
		addRow(32'h00289a83, 32'hfffffffd, 1); // lh x21, 2(x17)
		addRow(32'h0008db03, 32'h00000521, 1); // lhu x22, 0(x17)
		addRow(32'h0008ab83, 32'hfffd0521, 1); // lw x23, 0(x17)
		addRow(32'h01208463, 32'h00000001, 1); // beq x1, x18, +8 taken
		addRow(fillerWord, 32'h0, 0);
		addRow(32'h01209463, 32'h00000000, 1); // bne x1, x18, +8
		addRow(32'h00114463, 32'h00000001, 1); // blt x2, x1, +8 taken
		addRow(fillerWord, 32'h0, 0);
		addRow(32'h00115463, 32'h00000000, 1); // bge x2, x1, +8
		addRow(32'h0020e463, 32'h00000001, 1); // bltu x1, x2, +8 taken
		addRow(fillerWord, 32'h0, 0);
		addRow(32'h0020f463, 32'h00000000, 1); // bgeu x1, x2, +8
		addRow(32'h00800c6f, 32'h00000094, 1); // jal x24, +8 at 0x90
		addRow(fillerWord, 32'h0, 0);
		addRow(32'h010c0c93, 32'h000000a4, 1); // addi x25, x24, 16
		addRow(32'h005c8d67, 32'h000000a0, 1); // jalr x26, 5(x25) lands on 0xa8
		addRow(fillerWord, 32'h0, 0);
		addRow(fillerWord, 32'h0, 0);
		addRow(rvMemPkg::haltInstrFirst, 32'h0000000c, 1);
		addRow(rvMemPkg::haltInstrSecond, 32'h000000b0, 1); // link of jalr at 0xac
	endtask

	task automatic runWatchdog();
		#((progWords.size() + 5 + 10) * clkPeriod);
		$display("Watchdog expired before the program reached its end");
		$display("Some tests failed");
		$finish;
	endtask

	initial begin
		int  liveRows;
		int  retired;
		bit  first;
		CLK      = 1'b0;
		RSTn     = 1'b1;
		errors   = 0;
		checks   = 0;
		liveRows = 0;
		first    = 1'b1;
		buildProgram();
		for (int i = 0; i < progWords.size(); i++)
			imem.words[i] = progWords[i];
		fork
			runWatchdog();
		join_none

		repeat (5) begin
			@(negedge CLK);
			checkValue("iMemCsn in reset", {31'h0, iMemCsn}, 32'h1);
			checkValue("dMemCsn in reset", {31'h0, dMemCsn}, 32'h1);
			checkValue("dMemWen in reset", {31'h0, dMemWen}, 32'h1);
			checkValue("rfWe in reset", {31'h0, rfWe}, 32'h0);
			checkValue("numInst in reset", numInst, 32'h0);
		end
		RSTn = 1'b0; // first cycle out of reset starts at this edge

		for (int i = 0; i < progWords.size(); i++) begin
			if (progLive[i]) begin
				if (!first)
					@(negedge CLK);
				first = 1'b0;
				liveRows++;
				checkValue($sformatf("iMemCsn of row %0d", i), {31'h0, iMemCsn}, 32'h0);
				checkValue($sformatf("fetch address of row %0d", i), {20'h0, iMemAddr},
					32'(4 * i));
				checkValue($sformatf("outputPort of row %0d", i), outputPort, progWant[i]);
				// data port takes the word address of the effective address
				if (progWords[i][6:0] == rvIsaPkg::opStore) begin
					checkValue($sformatf("dMemWen of row %0d", i), {31'h0, dMemWen}, 32'h0);
					checkValue($sformatf("dMemAddr of row %0d", i), {20'h0, dMemAddr},
						progWant[i] >> 2);
				end
			end
		end

		// jalr of the halt pair is fetched but never retires
		retired = liveRows - 1;
		checkValue("halt on second halt word", {31'h0, halt}, 32'h1);
		checkValue("numInst on second halt word", numInst, 32'(retired));
		repeat (3) begin
			@(negedge CLK);
			checkValue("halt after halt pair", {31'h0, halt}, 32'h1);
			checkValue("numInst after halt pair", numInst, 32'(retired));
		end

		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

// ==== list.f ====
logic/rvIsaPkg.sv
logic/rvMemPkg.sv
logic/fetchUnit.sv
logic/instrDecoder.sv
logic/aluUnit.sv
logic/memAccessUnit.sv
logic/riscvCore.sv
tests/coreModels.sv
tests/coreTb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module coreTb -Mdir build -f list.f

./build/VcoreTb | tee sim.log

if grep -q "Some tests failed" sim.log; then
	echo "simulation reported failures, see sim.log"
	exit 1
fi
echo "simulation finished without failures, see sim.log"
